//--- Bender.yml
package:
  name: hci_queues

export_include_dirs:
  - verilog

sources:
  - verilog/hci_queue_pkg.sv
  - verilog/hci_queue_if.sv
  - verilog/hci_queue_fifo.sv
  - verilog/hci_csr_regs.sv
  - verilog/hci_queues_top.sv
  - target: test
    files:
      - tests/hci_queues_chk.sv
      - tests/hci_queues_tb.sv

//--- tests/hci_queues_chk.sv
// Assumes the CSR master issues one access at a time, so acks never come back to back
`timescale 1ns/10ps
`include "hci_queue_macros.svh"

module hci_queues_chk (
  input logic                           aclk,
  input logic                           arst_n_i,
  input logic                           rd_ack_i,
  input logic                           wr_ack_i,
  input logic                           cmd_rvalid_i,
  input logic                           cmd_rready_i,
  input logic [`HCI_CMD_DATA_WIDTH-1:0] cmd_rdata_i
);

  int unsigned fail_count = 0;

  rd_ack_single_a: assert property (@(posedge aclk) disable iff (!arst_n_i)
    rd_ack_i |=> !rd_ack_i)
    else begin
      $error("read ack high for more than one cycle");
      fail_count++;
    end

  wr_ack_single_a: assert property (@(posedge aclk) disable iff (!arst_n_i)
    wr_ack_i |=> !wr_ack_i)
    else begin
      $error("write ack high for more than one cycle");
      fail_count++;
    end

  ack_exclusive_a: assert property (@(posedge aclk) disable iff (!arst_n_i)
    !(rd_ack_i && wr_ack_i))
    else begin
      $error("read and write ack high together");
      fail_count++;
    end

  // Head entry must hold under back-pressure
  cmd_stable_a: assert property (@(posedge aclk) disable iff (!arst_n_i)
    (cmd_rvalid_i && !cmd_rready_i) |=> $stable(cmd_rdata_i))
    else begin
      $error("command data changed while stalled");
      fail_count++;
    end

  // Valid may only drop after a handshake
  cmd_valid_hold_a: assert property (@(posedge aclk) disable iff (!arst_n_i)
    (cmd_rvalid_i && !cmd_rready_i) |=> cmd_rvalid_i)
    else begin
      $error("command valid dropped without a pop");
      fail_count++;
    end

endmodule

bind hci_queues_top hci_queues_chk u_chk (
  .aclk        (aclk),
  .arst_n_i    (arst_n_i),
  .rd_ack_i    (s_cpuif_rd_ack_o),
  .wr_ack_i    (s_cpuif_wr_ack_o),
  .cmd_rvalid_i(hci_cmd_rvalid_o),
  .cmd_rready_i(hci_cmd_rready_i),
  .cmd_rdata_i (hci_cmd_rdata_o)
);

//--- tests/hci_queues_tb.sv
// Expects 8-entry queues and reset thresholds of 1; stops at the first mismatch
`timescale 1ns/10ps
`include "hci_queue_macros.svh"

module hci_queues_tb;

  import hci_queue_pkg::*;

  localparam int unsigned Depth        = `HCI_CMD_FIFO_DEPTH;
  localparam int unsigned DepthWidth   = $clog2(Depth + 1);
  localparam int unsigned CmdThld      = 3;
  localparam int unsigned RespThld     = 4;
  localparam int unsigned NumOrderCmds = 12;
  localparam int unsigned NumRandOps   = 40;
  // Roughly four times the cycles the whole sequence takes
  localparam int unsigned TimeoutCycles =
      4 * (6 * NumOrderCmds + 6 * NumRandOps + 24 * (Depth + 1));

  logic                            aclk;
  logic                            arst_n_i;
  logic                            s_cpuif_req_i;
  logic                            s_cpuif_req_is_wr_i;
  logic [`HCI_CSR_ADDR_WIDTH-1:0]  s_cpuif_addr_i;
  logic [`HCI_CSR_DATA_WIDTH-1:0]  s_cpuif_wr_data_i;
  logic                            s_cpuif_rd_ack_o;
  logic                            s_cpuif_rd_err_o;
  logic [`HCI_CSR_DATA_WIDTH-1:0]  s_cpuif_rd_data_o;
  logic                            s_cpuif_wr_ack_o;
  logic                            s_cpuif_wr_err_o;
  logic                            hci_cmd_rvalid_o;
  logic                            hci_cmd_rready_i;
  logic [`HCI_CMD_DATA_WIDTH-1:0]  hci_cmd_rdata_o;
  logic                            hci_cmd_full_o;
  logic                            hci_cmd_empty_o;
  logic [DepthWidth-1:0]           hci_cmd_depth_o;
  logic [`HCI_THLD_WIDTH-1:0]      hci_cmd_ready_thld_o;
  logic                            hci_cmd_ready_thld_trig_o;
  logic                            hci_resp_wvalid_i;
  logic                            hci_resp_wready_o;
  logic [`HCI_RESP_DATA_WIDTH-1:0] hci_resp_wdata_i;
  logic                            hci_resp_full_o;
  logic                            hci_resp_empty_o;
  logic [DepthWidth-1:0]           hci_resp_depth_o;
  logic [`HCI_THLD_WIDTH-1:0]      hci_resp_ready_thld_o;
  logic                            hci_resp_ready_thld_trig_o;

  integer      seed = 32'hb7de;
  string       test_name = "reset";
  logic        drain_en = 1'b0;
  logic [63:0] exp_cmd_q[$];
  logic [31:0] exp_resp_q[$];

  hci_queues_top u_hci_queues_top (.*);

  initial begin
    aclk = 1'b0;
    forever #10 aclk = ~aclk;
  end

  // Low word is written first and lands in the lower half
  function automatic logic [63:0] ref_cmd(input logic [31:0] lo, input logic [31:0] hi);
    return {hi, lo};
  endfunction

  task automatic fail_run();
    $display("Test FAILED");
    $fatal(1, "stopping in test %s", test_name);
  endtask

  task automatic check_value(input string what, input logic [63:0] exp,
                             input logic [63:0] act);
    assert (act === exp) else begin
      $display("error %s %s: expected %0h, actual %0h", test_name, what, exp, act);
      fail_run();
    end
  endtask

  task automatic next_cycle();
    @(posedge aclk);
    #2;
  endtask

  task automatic csr_access(input logic wr, input logic [3:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
    next_cycle();
    s_cpuif_req_i       = 1'b1;
    s_cpuif_req_is_wr_i = wr;
    s_cpuif_addr_i      = addr;
    s_cpuif_wr_data_i   = wdata;
    next_cycle();
    s_cpuif_req_i = 1'b0;
    while (!(wr ? s_cpuif_wr_ack_o : s_cpuif_rd_ack_o)) begin
      next_cycle();
    end
    rdata = s_cpuif_rd_data_o;
    err   = wr ? s_cpuif_wr_err_o : s_cpuif_rd_err_o;
  endtask

  task automatic write_cmd(input logic [31:0] lo, input logic [31:0] hi, output logic err);
    logic [31:0] rd;
    logic        lo_err;
    csr_access(1'b1, CMD_PORT_A, lo, rd, lo_err);
    check_value("cmd low word err", 0, lo_err);
    csr_access(1'b1, CMD_PORT_A, hi, rd, err);
    if (!err) begin
      exp_cmd_q.push_back(ref_cmd(lo, hi));
    end
  endtask

  task automatic read_resp();
    logic [31:0] rd;
    logic        err;
    logic [31:0] exp;
    exp = exp_resp_q.pop_front();
    csr_access(1'b0, RESP_PORT_A, '0, rd, err);
    check_value("resp read err", 0, err);
    check_value("resp data", exp, rd);
  endtask

  task automatic resp_push(input logic [31:0] data);
    next_cycle();
    hci_resp_wvalid_i = 1'b1;
    hci_resp_wdata_i  = data;
    while (!hci_resp_wready_o) begin
      next_cycle();
    end
    next_cycle();
    hci_resp_wvalid_i = 1'b0;
    exp_resp_q.push_back(data);
  endtask

  task automatic read_status(output logic [7:0] cmd_depth, output logic [7:0] resp_depth);
    logic [31:0] rd;
    logic        err;
    csr_access(1'b0, QUEUE_STATUS_A, '0, rd, err);
    check_value("status read err", 0, err);
    cmd_depth  = rd[7:0];
    resp_depth = rd[15:8];
  endtask

  task automatic wait_cmd_drained();
    while (exp_cmd_q.size() != 0) begin
      @(posedge aclk);
    end
    next_cycle();
    check_value("cmd empty after drain", 1, hci_cmd_empty_o);
  endtask

  // Controller side, random back-pressure and in-order check of every pop
  initial begin : cmd_consumer
    logic [63:0] exp;
    forever begin
      next_cycle();
      hci_cmd_rready_i = drain_en && (($random(seed) & 3) != 0);
      if (hci_cmd_rvalid_o && hci_cmd_rready_i) begin
        assert (exp_cmd_q.size() != 0) else begin
          $display("command %0h delivered that was never accepted", hci_cmd_rdata_o);
          fail_run();
        end
        exp = exp_cmd_q.pop_front();
        check_value("cmd data", exp, hci_cmd_rdata_o);
      end
    end
  end

  initial begin : protocol_monitor
    forever begin
      @(negedge aclk);
      assert (u_hci_queues_top.u_chk.fail_count == 0) else begin
        $display("protocol assertion failed in test %s", test_name);
        fail_run();
      end
    end
  end

  initial begin : watchdog
    repeat (TimeoutCycles) @(posedge aclk);
    $display("timeout after %0d cycles, the test sequence did not finish", TimeoutCycles);
    fail_run();
  end

  initial begin : main
    logic [31:0] rd;
    logic        err;
    logic [7:0]  cmd_depth;
    logic [7:0]  resp_depth;
    logic [1:0]  op;

    arst_n_i            = 1'b0;
    s_cpuif_req_i       = 1'b0;
    s_cpuif_req_is_wr_i = 1'b0;
    s_cpuif_addr_i      = '0;
    s_cpuif_wr_data_i   = '0;
    hci_cmd_rready_i    = 1'b0;
    hci_resp_wvalid_i   = 1'b0;
    hci_resp_wdata_i    = '0;
    repeat (4) @(posedge aclk);
    #2;
    arst_n_i = 1'b1;

    check_value("cmd empty", 1, hci_cmd_empty_o);
    check_value("resp empty", 1, hci_resp_empty_o);
    check_value("cmd rvalid", 0, hci_cmd_rvalid_o);
    check_value("resp wready", 1, hci_resp_wready_o);
    check_value("cmd trig", 1, hci_cmd_ready_thld_trig_o);
    check_value("resp trig", 0, hci_resp_ready_thld_trig_o);
    check_value("cmd depth out", 0, hci_cmd_depth_o);
    check_value("resp depth out", 0, hci_resp_depth_o);
    check_value("cmd thld out", `HCI_CMD_THLD_RESET, hci_cmd_ready_thld_o);
    check_value("resp thld out", `HCI_RESP_THLD_RESET, hci_resp_ready_thld_o);
    read_status(cmd_depth, resp_depth);
    check_value("cmd depth", 0, cmd_depth);
    check_value("resp depth", 0, resp_depth);
    csr_access(1'b0, QUEUE_THLD_CTRL_A, '0, rd, err);
    check_value("thresholds", {8'(`HCI_RESP_THLD_RESET), 8'(`HCI_CMD_THLD_RESET)}, rd);

    test_name = "cmd_order";
    drain_en  = 1'b1;
    repeat (NumOrderCmds) begin
      write_cmd($random(seed), $random(seed), err);
      check_value("cmd write err", 0, err);
    end
    wait_cmd_drained();

    test_name = "resp_order";
    repeat (5) resp_push($random(seed));
    read_status(cmd_depth, resp_depth);
    check_value("resp depth", 5, resp_depth);
    repeat (3) read_resp();
    read_status(cmd_depth, resp_depth);
    check_value("resp depth", 2, resp_depth);
    repeat (2) read_resp();
    read_status(cmd_depth, resp_depth);
    check_value("resp depth", 0, resp_depth);

    test_name = "thresholds";
    drain_en  = 1'b0;
    csr_access(1'b1, QUEUE_THLD_CTRL_A, {8'(RespThld), 8'(CmdThld)}, rd, err);
    check_value("threshold write err", 0, err);
    csr_access(1'b0, QUEUE_THLD_CTRL_A, '0, rd, err);
    check_value("threshold readback", {8'(RespThld), 8'(CmdThld)}, rd);
    check_value("cmd thld out", CmdThld, hci_cmd_ready_thld_o);
    check_value("resp thld out", RespThld, hci_resp_ready_thld_o);
    for (int d = 0; d <= Depth; d++) begin
      read_status(cmd_depth, resp_depth);
      check_value("cmd depth", d, cmd_depth);
      check_value("cmd depth out", d, hci_cmd_depth_o);
      check_value("cmd trig", (Depth - d) >= CmdThld, hci_cmd_ready_thld_trig_o);
      if (d < Depth) begin
        write_cmd($random(seed), $random(seed), err);
        check_value("cmd write err", 0, err);
      end
    end

    test_name = "errors";
    write_cmd($random(seed), $random(seed), err);
    check_value("ninth cmd err", 1, err);
    check_value("cmd full", 1, hci_cmd_full_o);
    drain_en = 1'b1;
    wait_cmd_drained();
    drain_en = 1'b0;

    test_name = "thresholds";
    for (int d = 0; d <= Depth; d++) begin
      read_status(cmd_depth, resp_depth);
      check_value("resp depth", d, resp_depth);
      check_value("resp depth out", d, hci_resp_depth_o);
      check_value("resp empty", d == 0, hci_resp_empty_o);
      check_value("resp full", d == Depth, hci_resp_full_o);
      check_value("resp trig", d >= RespThld, hci_resp_ready_thld_trig_o);
      if (d < Depth) begin
        resp_push($random(seed));
      end
    end

    test_name = "errors";
    check_value("resp wready when full", 0, hci_resp_wready_o);
    repeat (Depth) read_resp();
    csr_access(1'b0, RESP_PORT_A, '0, rd, err);
    check_value("empty resp read err", 1, err);
    check_value("empty resp read data", 0, rd);

    test_name = "random";
    drain_en  = 1'b1;
    repeat (NumRandOps) begin
      op = 2'($random(seed));
      case (op)
        2'd0: begin
          write_cmd($random(seed), $random(seed), err);
          check_value("cmd write err", 0, err);
        end
        2'd1: begin
          if (exp_resp_q.size() < Depth) begin
            resp_push($random(seed));
          end
        end
        2'd2: begin
          if (exp_resp_q.size() != 0) begin
            read_resp();
          end
        end
        default: begin
          read_status(cmd_depth, resp_depth);
          check_value("resp depth", exp_resp_q.size(), resp_depth);
        end
      endcase
    end
    while (exp_resp_q.size() != 0) begin
      read_resp();
    end
    wait_cmd_drained();

    if (u_hci_queues_top.u_chk.fail_count == 0) begin
      $display("Test OK");
      $finish;
    end else begin
      $display("protocol assertion failed in test %s", test_name);
      fail_run();
    end
  end

endmodule

//--- verilog/hci_csr_regs.sv
// One access in flight, answered next cycle; unmapped offsets ack with an error
`timescale 1ns/10ps
`include "hci_queue_macros.svh"

module hci_csr_regs (
  input  logic                           aclk,
  input  logic                           arst_n_i,

  input  logic                           csr_req_i,
  input  logic                           csr_req_is_wr_i,
  input  logic [`HCI_CSR_ADDR_WIDTH-1:0] csr_addr_i,
  input  logic [`HCI_CSR_DATA_WIDTH-1:0] csr_wr_data_i,
  output logic                           csr_rd_ack_o,
  output logic                           csr_rd_err_o,
  output logic [`HCI_CSR_DATA_WIDTH-1:0] csr_rd_data_o,
  output logic                           csr_wr_ack_o,
  output logic                           csr_wr_err_o,

  hci_queue_if.regs                      cmd_q,
  hci_queue_if.regs                      resp_q
);

  import hci_queue_pkg::*;

  hci_csr_addr_e                  addr;
  cmd_asm_state_e                 asm_state_q;

  logic                           wr_req;
  logic                           rd_req;
  logic                           cmd_wr;
  logic                           resp_pop;

  logic [`HCI_CSR_DATA_WIDTH-1:0] rd_data_d;
  logic                           rd_err_d;
  logic                           wr_err_d;

  logic [`HCI_CSR_DATA_WIDTH-1:0] cmd_lo_q;
  logic [`HCI_CMD_DATA_WIDTH-1:0] cmd_word_q;
  logic                           cmd_push_q;
  logic [`HCI_THLD_WIDTH-1:0]     cmd_thld_q;
  logic [`HCI_THLD_WIDTH-1:0]     resp_thld_q;

  assign addr   = hci_csr_addr_e'(csr_addr_i);
  assign wr_req = csr_req_i && csr_req_is_wr_i;
  assign rd_req = csr_req_i && !csr_req_is_wr_i;
  assign cmd_wr = wr_req && (addr == CMD_PORT_A);

  // Head is captured and popped on the same edge
  assign resp_pop = rd_req && (addr == RESP_PORT_A) && !resp_q.empty;

  always_comb begin
    rd_data_d = '0;
    rd_err_d  = 1'b0;
    wr_err_d  = 1'b0;
    case (addr)
      CMD_PORT_A: begin
        // Only the high word can overflow the queue
        wr_err_d = (asm_state_q == CMD_HI_S) && cmd_q.full;
      end
      RESP_PORT_A: begin
        rd_data_d = resp_q.empty ? '0 : resp_q.rdata;
        rd_err_d  = resp_q.empty;
        wr_err_d  = 1'b1;
      end
      QUEUE_THLD_CTRL_A: begin
        rd_data_d[7:0]  = 8'(cmd_thld_q);
        rd_data_d[15:8] = 8'(resp_thld_q);
      end
      QUEUE_STATUS_A: begin
        rd_data_d[7:0]  = 8'(cmd_q.depth);
        rd_data_d[15:8] = 8'(resp_q.depth);
        wr_err_d        = 1'b1;
      end
      default: begin
        rd_err_d = 1'b1;
        wr_err_d = 1'b1;
      end
    endcase
  end

  always_ff @(posedge aclk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      csr_rd_ack_o  <= 1'b0;
      csr_rd_err_o  <= 1'b0;
      csr_rd_data_o <= '0;
      csr_wr_ack_o  <= 1'b0;
      csr_wr_err_o  <= 1'b0;
      asm_state_q   <= CMD_LO_S;
      cmd_push_q    <= 1'b0;
      cmd_thld_q    <= `HCI_THLD_WIDTH'(`HCI_CMD_THLD_RESET);
      resp_thld_q   <= `HCI_THLD_WIDTH'(`HCI_RESP_THLD_RESET);
    end else begin
      csr_rd_ack_o  <= rd_req;
      csr_rd_err_o  <= rd_req && rd_err_d;
      csr_rd_data_o <= rd_req ? rd_data_d : '0;
      csr_wr_ack_o  <= wr_req;
      csr_wr_err_o  <= wr_req && wr_err_d;
      cmd_push_q    <= 1'b0;

      // A dropped command still returns assembly to the low word
      if (cmd_wr) begin
        if (asm_state_q == CMD_LO_S) begin
          asm_state_q <= CMD_HI_S;
        end else begin
          asm_state_q <= CMD_LO_S;
          cmd_push_q  <= !cmd_q.full;
        end
      end

      if (wr_req && (addr == QUEUE_THLD_CTRL_A)) begin
        cmd_thld_q  <= csr_wr_data_i[`HCI_THLD_WIDTH-1:0];
        resp_thld_q <= csr_wr_data_i[8 +: `HCI_THLD_WIDTH];
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (cmd_wr && (asm_state_q == CMD_LO_S)) begin
      cmd_lo_q <= csr_wr_data_i;
    end
    if (cmd_wr && (asm_state_q == CMD_HI_S)) begin
      cmd_word_q <= {csr_wr_data_i, cmd_lo_q};
    end
  end

  // Push lands in the ack cycle
  assign cmd_q.push  = cmd_push_q;
  assign cmd_q.pop   = 1'b0;
  assign cmd_q.wdata = cmd_word_q;
  assign cmd_q.thld  = cmd_thld_q;

  assign resp_q.push  = 1'b0;
  assign resp_q.pop   = resp_pop;
  assign resp_q.wdata = '0;
  assign resp_q.thld  = resp_thld_q;

endmodule

//--- verilog/hci_queue_fifo.sv
// Push on full and pop on empty are dropped; a push into an empty queue is visible next cycle
`timescale 1ns/10ps
`include "hci_queue_macros.svh"

module hci_queue_fifo #(
  parameter int unsigned Width = `HCI_RESP_DATA_WIDTH,
  parameter int unsigned Depth = `HCI_RESP_FIFO_DEPTH,
  parameter hci_queue_pkg::thld_mode_e Mode = hci_queue_pkg::THLD_USED
) (
  input  logic             aclk,
  input  logic             arst_n_i,

  hci_queue_if.queue       q,

  input  logic             ctl_push_i,
  input  logic             ctl_pop_i,
  input  logic [Width-1:0] ctl_wdata_i,

  output logic             thld_trig_o
);

  import hci_queue_pkg::*;

  localparam int unsigned DepthWidth = $clog2(Depth + 1);
  localparam int unsigned PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CmpWidth =
      (`HCI_THLD_WIDTH > DepthWidth) ? `HCI_THLD_WIDTH : DepthWidth;

  logic [Width-1:0]      mem [Depth];
  logic [PtrWidth-1:0]   wr_ptr;
  logic [PtrWidth-1:0]   rd_ptr;
  logic [DepthWidth-1:0] count;

  logic                  push_req;
  logic                  pop_req;
  logic [Width-1:0]      push_data;
  logic                  do_push;
  logic                  do_pop;
  logic [CmpWidth-1:0]   level;

  function automatic logic [PtrWidth-1:0] ptr_inc(input logic [PtrWidth-1:0] ptr);
    return (ptr == PtrWidth'(Depth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  // Used-mode queues are filled by the controller, free-mode queues by software
  assign push_req  = (Mode == THLD_USED) ? ctl_push_i : q.push;
  assign push_data = (Mode == THLD_USED) ? ctl_wdata_i : q.wdata;
  assign pop_req   = (Mode == THLD_USED) ? q.pop : ctl_pop_i;

  assign do_push = push_req && !q.full;
  assign do_pop  = pop_req && !q.empty;

  always_ff @(posedge aclk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (do_pop) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      if (do_push && !do_pop) begin
        count <= count + 1'b1;
      end else if (do_pop && !do_push) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  // Head entry falls through
  assign q.rdata = mem[rd_ptr];
  assign q.depth = count;
  assign q.full  = (count == DepthWidth'(Depth));
  assign q.empty = (count == '0);

  assign level = (Mode == THLD_FREE) ? CmpWidth'(Depth) - CmpWidth'(count)
                                     : CmpWidth'(count);

  assign thld_trig_o = (level >= CmpWidth'(q.thld));

endmodule

//--- verilog/hci_queue_if.sv
// Carries no clock; both sides sample it on the shared queue clock
`timescale 1ns/10ps
`include "hci_queue_macros.svh"

interface hci_queue_if #(
  parameter int unsigned Width = 32,
  parameter int unsigned Depth = 8
);

  localparam int unsigned DepthWidth = $clog2(Depth + 1);

  // Register block side
  logic                       push;
  logic                       pop;
  logic [Width-1:0]           wdata;
  logic [`HCI_THLD_WIDTH-1:0] thld;

  // Queue side, rdata is the head entry
  logic [Width-1:0]           rdata;
  logic [DepthWidth-1:0]      depth;
  logic                       full;
  logic                       empty;

  modport regs (
    output push, pop, wdata, thld,
    input  rdata, depth, full, empty
  );

  modport queue (
    input  push, pop, wdata, thld,
    output rdata, depth, full, empty
  );

endinterface

//--- verilog/hci_queue_macros.svh
// Depths up to 255 entries fit the 8-bit status fields; CSR data must be half the command width
`ifndef HCI_QUEUE_MACROS_SVH
`define HCI_QUEUE_MACROS_SVH

// CSR bus
`define HCI_CSR_DATA_WIDTH 32
`define HCI_CSR_ADDR_WIDTH 4

// Queue sizes
`define HCI_CMD_FIFO_DEPTH 8
`define HCI_RESP_FIFO_DEPTH 8
`define HCI_CMD_DATA_WIDTH 64
`define HCI_RESP_DATA_WIDTH 32

// Ready thresholds
`define HCI_THLD_WIDTH 8
`define HCI_CMD_THLD_RESET 1
`define HCI_RESP_THLD_RESET 1

`endif

//--- verilog/hci_queue_pkg.sv
// Register offsets are word aligned in a 4-bit space; other offsets are unmapped
`include "hci_queue_macros.svh"

package hci_queue_pkg;

  // Register map, also the set of CSR opcodes
  typedef enum logic [`HCI_CSR_ADDR_WIDTH-1:0] {
    CMD_PORT_A        = 4'h0,
    RESP_PORT_A       = 4'h4,
    QUEUE_THLD_CTRL_A = 4'h8,
    QUEUE_STATUS_A    = 4'hC
  } hci_csr_addr_e;

  // Command assembly from two CSR words
  typedef enum logic {
    CMD_LO_S,
    CMD_HI_S
  } cmd_asm_state_e;

  // Which occupancy the ready threshold is compared against
  typedef enum logic {
    THLD_FREE,
    THLD_USED
  } thld_mode_e;

endpackage

//--- verilog/hci_queues_top.sv
// Commands reach the controller two cycles after the high-word request; no AXI front end
`timescale 1ns/10ps
`include "hci_queue_macros.svh"

module hci_queues_top #(
  localparam int unsigned CmdDepthWidth  = $clog2(`HCI_CMD_FIFO_DEPTH + 1),
  localparam int unsigned RespDepthWidth = $clog2(`HCI_RESP_FIFO_DEPTH + 1)
) (
  input  logic                            aclk,
  input  logic                            arst_n_i,

  // CSR request bus
  input  logic                            s_cpuif_req_i,
  input  logic                            s_cpuif_req_is_wr_i,
  input  logic [`HCI_CSR_ADDR_WIDTH-1:0]  s_cpuif_addr_i,
  input  logic [`HCI_CSR_DATA_WIDTH-1:0]  s_cpuif_wr_data_i,
  output logic                            s_cpuif_rd_ack_o,
  output logic                            s_cpuif_rd_err_o,
  output logic [`HCI_CSR_DATA_WIDTH-1:0]  s_cpuif_rd_data_o,
  output logic                            s_cpuif_wr_ack_o,
  output logic                            s_cpuif_wr_err_o,

  // Command queue, controller side
  output logic                            hci_cmd_rvalid_o,
  input  logic                            hci_cmd_rready_i,
  output logic [`HCI_CMD_DATA_WIDTH-1:0]  hci_cmd_rdata_o,
  output logic                            hci_cmd_full_o,
  output logic                            hci_cmd_empty_o,
  output logic [CmdDepthWidth-1:0]        hci_cmd_depth_o,
  output logic [`HCI_THLD_WIDTH-1:0]      hci_cmd_ready_thld_o,
  output logic                            hci_cmd_ready_thld_trig_o,

  // Response queue, controller side
  input  logic                            hci_resp_wvalid_i,
  output logic                            hci_resp_wready_o,
  input  logic [`HCI_RESP_DATA_WIDTH-1:0] hci_resp_wdata_i,
  output logic                            hci_resp_full_o,
  output logic                            hci_resp_empty_o,
  output logic [RespDepthWidth-1:0]       hci_resp_depth_o,
  output logic [`HCI_THLD_WIDTH-1:0]      hci_resp_ready_thld_o,
  output logic                            hci_resp_ready_thld_trig_o
);

  import hci_queue_pkg::*;

  hci_queue_if #(
    .Width(`HCI_CMD_DATA_WIDTH),
    .Depth(`HCI_CMD_FIFO_DEPTH)
  ) cmd_q ();

  hci_queue_if #(
    .Width(`HCI_RESP_DATA_WIDTH),
    .Depth(`HCI_RESP_FIFO_DEPTH)
  ) resp_q ();

  hci_csr_regs u_csr_regs (
    .aclk           (aclk),
    .arst_n_i       (arst_n_i),
    .csr_req_i      (s_cpuif_req_i),
    .csr_req_is_wr_i(s_cpuif_req_is_wr_i),
    .csr_addr_i     (s_cpuif_addr_i),
    .csr_wr_data_i  (s_cpuif_wr_data_i),
    .csr_rd_ack_o   (s_cpuif_rd_ack_o),
    .csr_rd_err_o   (s_cpuif_rd_err_o),
    .csr_rd_data_o  (s_cpuif_rd_data_o),
    .csr_wr_ack_o   (s_cpuif_wr_ack_o),
    .csr_wr_err_o   (s_cpuif_wr_err_o),
    .cmd_q          (cmd_q.regs),
    .resp_q         (resp_q.regs)
  );

  // Software fills, controller drains
  hci_queue_fifo #(
    .Width(`HCI_CMD_DATA_WIDTH),
    .Depth(`HCI_CMD_FIFO_DEPTH),
    .Mode (THLD_FREE)
  ) u_cmd_fifo (
    .aclk       (aclk),
    .arst_n_i   (arst_n_i),
    .q          (cmd_q.queue),
    .ctl_push_i (1'b0),
    .ctl_pop_i  (hci_cmd_rvalid_o && hci_cmd_rready_i),
    .ctl_wdata_i('0),
    .thld_trig_o(hci_cmd_ready_thld_trig_o)
  );

  // Controller fills, software drains
  hci_queue_fifo #(
    .Width(`HCI_RESP_DATA_WIDTH),
    .Depth(`HCI_RESP_FIFO_DEPTH),
    .Mode (THLD_USED)
  ) u_resp_fifo (
    .aclk       (aclk),
    .arst_n_i   (arst_n_i),
    .q          (resp_q.queue),
    .ctl_push_i (hci_resp_wvalid_i && hci_resp_wready_o),
    .ctl_pop_i  (1'b0),
    .ctl_wdata_i(hci_resp_wdata_i),
    .thld_trig_o(hci_resp_ready_thld_trig_o)
  );

  assign hci_cmd_rvalid_o     = !cmd_q.empty;
  assign hci_cmd_rdata_o      = cmd_q.rdata;
  assign hci_cmd_full_o       = cmd_q.full;
  assign hci_cmd_empty_o      = cmd_q.empty;
  assign hci_cmd_depth_o      = cmd_q.depth;
  assign hci_cmd_ready_thld_o = cmd_q.thld;

  assign hci_resp_wready_o     = !resp_q.full;
  assign hci_resp_full_o       = resp_q.full;
  assign hci_resp_empty_o      = resp_q.empty;
  assign hci_resp_depth_o      = resp_q.depth;
  assign hci_resp_ready_thld_o = resp_q.thld;

endmodule

//--- vlog.f
+incdir+verilog
verilog/hci_queue_pkg.sv
verilog/hci_queue_if.sv
verilog/hci_queue_fifo.sv
verilog/hci_csr_regs.sv
verilog/hci_queues_top.sv
tests/hci_queues_chk.sv
tests/hci_queues_tb.sv
